// File: source/sprite_pkg.sv
package sprite_pkg;

	// pixel coordinate width, covers the 448-clock line
	localparam int coord_w = 9;

	// pattern pixel color width, 0 is transparent
	localparam int color_w = 6;

	// entries per line buffer bank
	localparam int buf_depth = 1 << coord_w;

	// sprite size step of 8 pixels
	localparam int size_shift = 3;

	// pattern memory address width
	localparam int pat_w = 16;

	// scanner FSM
	typedef enum logic [2:0] {
		s_idle      = 3'd0,
		s_attr      = 3'd1,
		s_check     = 3'd2,
		s_fetch_req = 3'd3,
		s_fetch_ack = 3'd4,
		s_write     = 3'd5,
		s_next      = 3'd6
	} scan_state_t;

	// byte offsets inside the 8-byte attribute record
	// bytes 2 and 3 are reserved
	typedef enum logic [2:0] {
		// bit 7 enables the sprite
		attr_ctrl = 3'd0,
		// pattern base, in 256-pixel units
		attr_base = 3'd1,
		attr_x_lo = 3'd4,
		// bit 0 is x[8], bits 3:1 width code
		attr_x_hi = 3'd5,
		attr_y_lo = 3'd6,
		// bit 0 is y[8], bits 3:1 height code
		attr_y_hi = 3'd7
	} attr_byte_t;

endpackage

// File: source/line_buffer.sv
`timescale 1ns/1ns

module line_buffer
	import sprite_pkg::*;
(
	input  logic               clk,
	input  logic               bank,
	input  logic               scan_we,
	input  logic [coord_w-1:0] scan_addr,
	input  logic [color_w:0]   scan_data,
	input  logic [coord_w-1:0] rd_addr,
	input  logic               clr_we,
	output logic [color_w:0]   rd_data
);

	// two banks of bit 6 valid plus color
	logic [color_w:0] mem [0:1][0:buf_depth-1];

	// front bank is shown while the back bank is rendered
	logic front_sel;
	logic back_sel;

	// previous read address is the clear target
	logic [coord_w-1:0] rd_addr_q;

	assign front_sel = bank;
	assign back_sel  = ~bank;

	// back bank write path, front bank read path and clear after read
	always_ff @(posedge clk)
	begin
		// scanner writes always land in the back bank
		if (scan_we)
			mem[back_sel][scan_addr] <= scan_data;
		// wipe the pixel read on the previous cycle
		if (clr_we)
			mem[front_sel][rd_addr_q] <= '0;
		rd_data   <= mem[front_sel][rd_addr];
		rd_addr_q <= rd_addr;
	end

endmodule

// File: source/sprite_scanner.sv
`timescale 1ns/1ns

module sprite_scanner
	import sprite_pkg::*;
#(
	parameter int num_sprites = 32,
	parameter int line_pixels = 360
)
(
	input  logic               clk,
	input  logic               line_start,
	input  logic [coord_w-1:0] vline,
	output logic [7:0]         sf_ra,
	input  logic [7:0]         sf_rd,
	output logic               pat_req,
	output logic [pat_w-1:0]   pat_addr,
	input  logic [color_w-1:0] pat_data,
	input  logic               pat_ack,
	output logic               scan_we,
	output logic [coord_w-1:0] scan_addr,
	output logic [color_w:0]   scan_data
);

	// first sprite scanned, lowest priority
	localparam logic [4:0] last_sprite = 5'(num_sprites - 1);
	// first x that is clipped
	localparam logic [coord_w:0] pix_limit = (coord_w + 1)'(line_pixels);

	scan_state_t state;
	logic [4:0] spr_idx;
	// attribute read step, 0..5
	logic [2:0] step;
	// whole table done for this line
	logic line_done;
	logic [5:0] col;

	// latched attribute fields
	logic               spr_on;
	logic [7:0]         pat_base;
	logic [coord_w-1:0] spr_x;
	logic [2:0]         w_code;
	logic [7:0]         y_lo;
	logic [5:0]         row;

	logic [6:0]         spr_w;
	logic [6:0]         spr_h;
	logic [coord_w-1:0] target_line;
	logic [coord_w-1:0] spr_y;
	logic [coord_w-1:0] dy;
	logic               hit;
	logic [coord_w:0]   x_sum;
	logic [pat_w-1:0]   row_off;

	// read step to record byte, skipping reserved bytes
	function automatic attr_byte_t step_byte(input logic [2:0] s);
		case (s)
			3'd0: step_byte = attr_ctrl;
			3'd1: step_byte = attr_base;
			3'd2: step_byte = attr_x_lo;
			3'd3: step_byte = attr_x_hi;
			3'd4: step_byte = attr_y_lo;
			default: step_byte = attr_y_hi;
		endcase
	endfunction

	// 8 bytes per sprite record
	assign sf_ra = {spr_idx, step_byte(step)};

	// sizes in pixels, (code + 1) * 8
	assign spr_w = 7'({1'b0, w_code} + 4'd1) << size_shift;
	// y_hi byte is live on sf_rd during s_check
	assign spr_h = 7'({1'b0, sf_rd[3:1]} + 4'd1) << size_shift;

	// rendering one line ahead of the display
	assign target_line = vline + 1'b1;
	assign spr_y = {sf_rd[0], y_lo};
	// modulo 512, so sprites above y wrap to large values
	assign dy  = target_line - spr_y;
	assign hit = spr_on && (dy < {2'b00, spr_h});

	// one extra bit so the right edge clip does not wrap
	assign x_sum = {1'b0, spr_x} + {4'd0, col};

	// base * 256 + row * width + col
	assign row_off  = {10'd0, row} * {9'd0, spr_w};
	assign pat_addr = {pat_base, 8'h00} + row_off + {10'd0, col};

	// FSM and handshake
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state     <= s_idle;
			spr_idx   <= last_sprite;
			step      <= 3'd0;
			line_done <= 1'b0;
			col       <= 6'd0;
			pat_req   <= 1'b0;
			scan_we   <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (!line_done)
						state <= s_attr;
				end
				// six reads back to back
				s_attr:
				begin
					step <= step + 3'd1;
					if (step == 3'd5)
						state <= s_check;
				end
				s_check:
				begin
					col <= 6'd0;
					if (hit)
						state <= s_fetch_req;
					else
						state <= s_next;
				end
				// previous ack must be gone first
				s_fetch_req:
				begin
					if (!pat_ack)
					begin
						pat_req <= 1'b1;
						state   <= s_fetch_ack;
					end
				end
				// waits here as long as memory stalls
				s_fetch_ack:
				begin
					if (pat_ack)
					begin
						pat_req <= 1'b0;
						scan_we <= (pat_data != '0) && (x_sum < pix_limit);
						state   <= s_write;
					end
				end
				s_write:
				begin
					scan_we <= 1'b0;
					if ({1'b0, col} == spr_w - 7'd1)
						state <= s_next;
					else
					begin
						col   <= col + 6'd1;
						state <= s_fetch_req;
					end
				end
				// count down, sprite 0 goes last and wins
				s_next:
				begin
					step <= 3'd0;
					if (spr_idx == 5'd0)
					begin
						line_done <= 1'b1;
						state     <= s_idle;
					end
					else
					begin
						spr_idx <= spr_idx - 5'd1;
						state   <= s_attr;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// attribute and pixel capture
	always_ff @(posedge clk)
	begin
		case (state)
			// data lags the address by one step
			s_attr:
			begin
				case (step)
					3'd1: spr_on <= sf_rd[7];
					3'd2: pat_base <= sf_rd;
					3'd3: spr_x[7:0] <= sf_rd;
					3'd4:
					begin
						spr_x[coord_w-1] <= sf_rd[0];
						w_code           <= sf_rd[3:1];
					end
					3'd5: y_lo <= sf_rd;
					default: ;
				endcase
			end
			// dy is below 64 on a hit
			s_check: row <= dy[5:0];
			s_fetch_ack:
			begin
				if (pat_ack)
				begin
					scan_addr <= x_sum[coord_w-1:0];
					scan_data <= {1'b1, pat_data};
				end
			end
			default: ;
		endcase
	end

endmodule

// File: source/raster_readout.sv
`timescale 1ns/1ns

module raster_readout
	import sprite_pkg::*;
#(
	parameter int line_pixels = 360
)
(
	input  logic               clk,
	input  logic               line_start,
	input  logic               pre_vline,
	input  logic               cend,
	input  logic               spr_en,
	output logic               bank,
	output logic [coord_w-1:0] vline,
	output logic [coord_w-1:0] rd_addr,
	output logic               clr_we,
	input  logic [color_w:0]   rd_data,
	output logic [color_w-1:0] spixel,
	output logic               spx_en
);

	localparam logic [coord_w:0] pix_limit = (coord_w + 1)'(line_pixels);

	// pixel counter
	logic [coord_w-1:0] hcount;
	// read strobe, then its one-cycle delay
	logic rd_stb;
	logic rd_stb_d;
	// pixel shown after gating
	logic pix_on;

	// line counter and bank bit run off line_start itself
	// pre_vline brings them to a known state
	always_ff @(posedge line_start)
	begin
		if (pre_vline)
		begin
			vline <= '0;
			bank  <= 1'b0;
		end
		else
		begin
			vline <= vline + 1'b1;
			bank  <= ~bank;
		end
	end

	// hcount and read pipeline
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			hcount   <= '0;
			rd_addr  <= '0;
			rd_stb   <= 1'b0;
			rd_stb_d <= 1'b0;
		end
		else
		begin
			rd_stb   <= cend;
			rd_stb_d <= rd_stb;
			// hold the address for the buffer read
			if (cend)
			begin
				rd_addr <= hcount;
				hcount  <= hcount + 1'b1;
			end
		end
	end

	// clear runs even with spr_en low
	assign clr_we = rd_stb_d;

	// valid bit, enable, right edge bound
	assign pix_on = rd_data[color_w] && spr_en && ({1'b0, rd_addr} < pix_limit);

	// output registers, hold between pixels
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			spixel <= '0;
			spx_en <= 1'b0;
		end
		else if (rd_stb_d)
		begin
			spx_en <= pix_on;
			spixel <= pix_on ? rd_data[color_w-1:0] : '0;
		end
	end

endmodule

// File: source/sprite_engine.sv
`timescale 1ns/1ns

module sprite_engine
	import sprite_pkg::*;
#(
	parameter int num_sprites = 32,
	parameter int line_pixels = 360
)
(
	input  logic               clk,
	input  logic               line_start,
	input  logic               pre_vline,
	input  logic               cend,
	input  logic               spr_en,
	// attribute file, one-cycle read
	output logic [7:0]         sf_ra,
	input  logic [7:0]         sf_rd,
	// pattern memory, four-phase req/ack
	output logic               pat_req,
	output logic [pat_w-1:0]   pat_addr,
	input  logic [color_w-1:0] pat_data,
	input  logic               pat_ack,
	// pixel out
	output logic [color_w-1:0] spixel,
	output logic               spx_en
);

	// back bank write path
	logic               scan_we;
	logic [coord_w-1:0] scan_addr;
	logic [color_w:0]   scan_data;

	// front bank read path
	logic [coord_w-1:0] rd_addr;
	logic               clr_we;
	logic [color_w:0]   rd_data;

	// line state from the readout
	logic               bank;
	logic [coord_w-1:0] vline;

	// renders line vline + 1 into the back bank
	sprite_scanner #(
		.num_sprites (num_sprites),
		.line_pixels (line_pixels)
	) u_scanner (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.sf_ra      (sf_ra),
		.sf_rd      (sf_rd),
		.pat_req    (pat_req),
		.pat_addr   (pat_addr),
		.pat_data   (pat_data),
		.pat_ack    (pat_ack),
		.scan_we    (scan_we),
		.scan_addr  (scan_addr),
		.scan_data  (scan_data)
	);

	// double line buffer
	line_buffer u_line_buffer (
		.clk       (clk),
		.bank      (bank),
		.scan_we   (scan_we),
		.scan_addr (scan_addr),
		.scan_data (scan_data),
		.rd_addr   (rd_addr),
		.clr_we    (clr_we),
		.rd_data   (rd_data)
	);

	// display side, also owns bank and line count
	raster_readout #(
		.line_pixels (line_pixels)
	) u_readout (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.cend       (cend),
		.spr_en     (spr_en),
		.bank       (bank),
		.vline      (vline),
		.rd_addr    (rd_addr),
		.clr_we     (clr_we),
		.rd_data    (rd_data),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

// File: sim/tb_sprite_memory.sv
`timescale 1ns/1ns

module tb_sprite_memory (
	input  logic        clk,
	input  logic [7:0]  sf_ra,
	output logic [7:0]  sf_rd,
	input  logic        pat_req,
	input  logic [15:0] pat_addr,
	output logic [5:0]  pat_data,
	output logic        pat_ack
);

	// 32 records of 8 bytes
	logic [7:0] attr_mem [0:255];
	// one 6-bit color per address
	logic [5:0] pat_mem [0:65535];
	// clocks from seeing pat_req to raising pat_ack
	int ack_delay;
	int wait_cnt;

	logic [7:0] sf_next;
	logic [5:0] data_next;
	logic       ack_next;

	initial
	begin
		sf_rd    = '0;
		pat_data = '0;
		pat_ack  = 1'b0;
		wait_cnt = 0;
	end

	always @(posedge clk)
	begin
		// sampled at the edge, like a register
		sf_next   = attr_mem[sf_ra];
		ack_next  = pat_ack;
		data_next = pat_data;
		if (pat_req && !pat_ack)
		begin
			// data and ack go up together
			if (wait_cnt >= ack_delay)
			begin
				ack_next  = 1'b1;
				data_next = pat_mem[pat_addr];
				wait_cnt  = 0;
			end
			else
				wait_cnt = wait_cnt + 1;
		end
		else
		begin
			wait_cnt = 0;
			// req gone, so release ack
			if (!pat_req)
				ack_next = 1'b0;
		end
		// outputs move 2 ns after the edge
		#2;
		sf_rd    = sf_next;
		pat_ack  = ack_next;
		pat_data = data_next;
	end

endmodule

// File: sim/tb_sprite_engine.sv
`timescale 1ns/1ns

module tb_sprite_engine
	import sprite_pkg::*;
();

	localparam int num_sprites = 32;
	localparam int line_pixels = 360;
	// cend pulses per line 3 clocks apart
	localparam int line_clocks = 448;
	localparam int idle_clocks = 40;
	localparam int req_timeout = 2000;
	localparam logic [31:0] seed = 32'h31a86ffa;

	logic               clk;
	logic               line_start;
	logic               pre_vline;
	logic               cend;
	logic               spr_en;
	logic [7:0]         sf_ra;
	logic [7:0]         sf_rd;
	logic               pat_req;
	logic [pat_w-1:0]   pat_addr;
	logic [color_w-1:0] pat_data;
	logic               pat_ack;
	logic [color_w-1:0] spixel;
	logic               spx_en;

	// {spx_en, spixel} of the line just run
	logic [color_w:0] got [0:line_clocks-1];
	// overlap results replayed under random ack delays
	logic [color_w:0] saved [0:15][0:line_clocks-1];

	int          errors;
	int          checks;
	int          tests;
	int          lit_pixels;
	bit          timed_out;
	bit          first_line;
	bit          rand_delay;
	logic [31:0] rng;

	sprite_engine #(
		.num_sprites (num_sprites),
		.line_pixels (line_pixels)
	) uut (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.cend       (cend),
		.spr_en     (spr_en),
		.sf_ra      (sf_ra),
		.sf_rd      (sf_rd),
		.pat_req    (pat_req),
		.pat_addr   (pat_addr),
		.pat_data   (pat_data),
		.pat_ack    (pat_ack),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

	tb_sprite_memory mem (
		.clk      (clk),
		.sf_ra    (sf_ra),
		.sf_rd    (sf_rd),
		.pat_req  (pat_req),
		.pat_addr (pat_addr),
		.pat_data (pat_data),
		.pat_ack  (pat_ack)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// new delay for each request that the memory sees one edge later
	always @(posedge pat_req)
	begin
		if (rand_delay)
		begin
			rng = xorshift(rng);
			mem.ack_delay = int'(rng[2:0]);
		end
	end

	// expected {valid, color} at pixel x of display line ln
	function automatic logic [color_w:0] model_pixel(input int ln, input int x);
		logic [color_w:0] res;
		int b;
		int sx;
		int sy;
		int w;
		int h;
		int dy;
		int addr;
		res = '0;
		if (x >= line_pixels)
			return res;
		// highest number first so sprite 0 lands last
		for (int s = num_sprites - 1; s >= 0; s--)
		begin
			b = s * 8;
			if (!mem.attr_mem[b + int'(attr_ctrl)][7])
				continue;
			sx = int'({mem.attr_mem[b + int'(attr_x_hi)][0], mem.attr_mem[b + int'(attr_x_lo)]});
			sy = int'({mem.attr_mem[b + int'(attr_y_hi)][0], mem.attr_mem[b + int'(attr_y_lo)]});
			w  = (int'(mem.attr_mem[b + int'(attr_x_hi)][3:1]) + 1) * 8;
			h  = (int'(mem.attr_mem[b + int'(attr_y_hi)][3:1]) + 1) * 8;
			// line distance modulo 512
			dy = (ln - sy) & 511;
			if (dy >= h || x < sx || x >= sx + w)
				continue;
			addr = (int'(mem.attr_mem[b + int'(attr_base)]) * 256 + dy * w + x - sx) & 16'hffff;
			// color 0 lets lower priority sprites through
			if (mem.pat_mem[addr] != '0)
				res = {1'b1, mem.pat_mem[addr]};
		end
		return res;
	endfunction

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (timed_out)
			return;
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// one line of line_start pulse then cend pulses then idle time
	task automatic drive_line(input int ls_clocks);
		int n;
		if (timed_out)
			return;
		@(posedge clk);
		#2;
		line_start = 1'b1;
		repeat (ls_clocks) @(posedge clk);
		#2;
		line_start = 1'b0;
		pre_vline  = 1'b0;
		for (int k = 0; k < line_clocks; k++)
		begin
			cend = 1'b1;
			@(posedge clk);
			#2;
			cend = 1'b0;
			// output lands on the second edge after the sampling edge
			repeat (2) @(posedge clk);
			#2;
			got[k] = {spx_en, spixel};
		end
		repeat (idle_clocks) @(posedge clk);
		#2;
		n = 0;
		while (pat_req && n < req_timeout)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (pat_req)
		begin
			timed_out = 1'b1;
			$display("pat_req did not fall within %0d clocks, scanner state %s",
				req_timeout, uut.u_scanner.state.name());
		end
	endtask

	task automatic check_line(input int ln, input bit en);
		logic [color_w:0] exp;
		for (int x = 0; x < line_clocks; x++)
		begin
			exp = en ? model_pixel(ln, x) : '0;
			if (got[x][color_w] === 1'b1)
				lit_pixels++;
			compare(got[x], exp, $sformatf("line %0d pixel %0d", ln, x));
		end
	endtask

	// frame from pre_vline with lines 0 and 1 unchecked
	// mode 1 saves the lines and mode 2 compares with them
	task automatic run_frame(input int lines, input int off_line, input int mode);
		lit_pixels = 0;
		for (int ln = 0; ln < lines; ln++)
		begin
			pre_vline = (ln == 0);
			spr_en    = (ln != off_line);
			drive_line(first_line ? 8 : 2);
			first_line = 1'b0;
			if (ln >= 2)
				check_line(ln, ln != off_line);
			for (int x = 0; x < line_clocks; x++)
			begin
				if (mode == 1)
					saved[ln][x] = got[x];
				else if (mode == 2 && ln >= 2)
					compare(got[x], saved[ln][x], $sformatf("rerun line %0d pixel %0d", ln, x));
			end
		end
	endtask

	// empty table and a pattern that depends on every address bit
	task automatic fill_memories();
		for (int a = 0; a < 256; a++)
			mem.attr_mem[a] = '0;
		for (int a = 0; a < 65536; a++)
			mem.pat_mem[a] = 6'(a ^ (a >> 6) ^ (a >> 12));
	endtask

	task automatic set_sprite(input int s, input int base, input int x, input int y,
		input int wc, input int hc);
		int b;
		b = s * 8;
		mem.attr_mem[b + int'(attr_ctrl)] = 8'h80;
		mem.attr_mem[b + int'(attr_base)] = 8'(base);
		mem.attr_mem[b + int'(attr_x_lo)] = 8'(x);
		mem.attr_mem[b + int'(attr_x_hi)] = 8'({wc[2:0], x[8]});
		mem.attr_mem[b + int'(attr_y_lo)] = 8'(y);
		mem.attr_mem[b + int'(attr_y_hi)] = 8'({hc[2:0], y[8]});
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before && !timed_out)
			$display("%s: ok", name);
		else
			$display("%s: %0d mismatches", name, errors - err_before);
	endtask

	// sprites 1 and 5 with a hole in sprite 1 over sprite 5
	task automatic load_overlap_table();
		fill_memories();
		set_sprite(1, 8, 200, 5, 1, 1);
		set_sprite(5, 12, 208, 9, 1, 1);
		for (int r = 4; r < 10; r++)
			for (int c = 8; c < 12; c++)
				mem.pat_mem[8 * 256 + r * 16 + c] = '0;
	endtask

	task automatic no_sprite_frames();
		int err0;
		err0 = errors;
		fill_memories();
		run_frame(5, -1, 0);
		compare(lit_pixels, 0, "pixels shown with no sprite");
		report_test("no enabled sprite", err0);
	endtask

	task automatic lone_sprite();
		int err0;
		err0 = errors;
		fill_memories();
		set_sprite(2, 4, 100, 3, 1, 0);
		run_frame(12, -1, 0);
		compare(lit_pixels > 0, 1, "single sprite shown");
		report_test("single 16x8 sprite", err0);
	endtask

	task automatic priority_overlap();
		int err0;
		err0 = errors;
		load_overlap_table();
		run_frame(16, -1, 1);
		compare(lit_pixels > 0, 1, "overlap sprites shown");
		report_test("overlap priority", err0);
	endtask

	task automatic right_edge_clip();
		int err0;
		err0 = errors;
		fill_memories();
		set_sprite(0, 20, 350, 4, 1, 0);
		run_frame(8, -1, 0);
		compare(lit_pixels > 0, 1, "edge sprite shown");
		report_test("right edge clip", err0);
	endtask

	task automatic blanked_line();
		int err0;
		err0 = errors;
		fill_memories();
		set_sprite(3, 4, 100, 3, 1, 0);
		// line 10 is the last sprite line and is blanked
		// its bank returns on line 12 with no sprite left, so it must be empty
		run_frame(13, 10, 0);
		report_test("output enable", err0);
	endtask

	task automatic random_ack_delays();
		int err0;
		err0 = errors;
		load_overlap_table();
		rng        = seed;
		rand_delay = 1'b1;
		run_frame(16, -1, 2);
		rand_delay    = 1'b0;
		mem.ack_delay = 1;
		report_test("random ack delays", err0);
	endtask

	initial
	begin
		clk        = 1'b0;
		line_start = 1'b0;
		pre_vline  = 1'b1;
		cend       = 1'b0;
		spr_en     = 1'b1;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		lit_pixels = 0;
		timed_out  = 1'b0;
		first_line = 1'b1;
		rand_delay = 1'b0;
		rng        = seed;
		mem.ack_delay = 1;
		no_sprite_frames();
		lone_sprite();
		priority_overlap();
		right_edge_clip();
		blanked_line();
		random_ack_delays();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: project.f
source/sprite_pkg.sv
source/line_buffer.sv
source/sprite_scanner.sv
source/raster_readout.sv
source/sprite_engine.sv
sim/tb_sprite_memory.sv
sim/tb_sprite_engine.sv

// File: Makefile
# Verilator flow for the sprite engine testbench

VERILATOR  ?= verilator
TOP        ?= tb_sprite_engine
DUT_TOP    ?= sprite_engine
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
